// File: hdl/sha256_cfg.svh
`ifndef SHA256_CFG_SVH
`define SHA256_CFG_SVH

`define SHA_WORD_BITS   32
`define SHA_MSG_BITS    24
`define SHA_BLOCK_BITS  512
`define SHA_ROUNDS      64
`define SHA_OUT_CREDITS 2
`define SHA_IN_CREDITS  1

// initial hash words from the standard
`define SHA_H0 32'h6a09e667
`define SHA_H1 32'hbb67ae85
`define SHA_H2 32'h3c6ef372
`define SHA_H3 32'ha54ff53a
`define SHA_H4 32'h510e527f
`define SHA_H5 32'h9b05688c
`define SHA_H6 32'h1f83d9ab
`define SHA_H7 32'h5be0cd19

`endif

// File: hdl/sha256_pkg.sv
`default_nettype none

`include "sha256_cfg.svh"

package sha256_pkg;

    typedef logic [`SHA_WORD_BITS-1:0]      word_t;
    typedef logic [`SHA_MSG_BITS-1:0]       msg_t;
    typedef logic [$clog2(`SHA_ROUNDS)-1:0] round_idx_t;

    // working variables, a is the most significant word
    typedef struct packed {
        word_t a;
        word_t b;
        word_t c;
        word_t d;
        word_t e;
        word_t f;
        word_t g;
        word_t h;
    } work_state_t;

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        ROUND,
        FINISH,
        SEND
    } ctrl_state_e;

    ////////////////////////////////////////////////////////////////////////////
    // bit functions
    ////////////////////////////////////////////////////////////////////////////

    function automatic word_t rotr(input word_t x, input int unsigned n);
        return (x >> n) | (x << (`SHA_WORD_BITS - n));
    endfunction

    function automatic word_t ch(input word_t x, input word_t y, input word_t z);
        return (x & y) ^ (~x & z);
    endfunction

    function automatic word_t maj(input word_t x, input word_t y, input word_t z);
        return (x & y) ^ (x & z) ^ (y & z);
    endfunction

    function automatic word_t big_sigma0(input word_t x);
        return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
    endfunction

    function automatic word_t big_sigma1(input word_t x);
        return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
    endfunction

    // schedule sigmas, the last term is a plain shift
    function automatic word_t small_sigma0(input word_t x);
        return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
    endfunction

    function automatic word_t small_sigma1(input word_t x);
        return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
    endfunction

endpackage

`default_nettype wire

// File: hdl/sha256_k_rom.sv
`default_nettype none

`include "sha256_cfg.svh"

// round constants, first 32 bits of the fractional cube roots of the first 64 primes
module sha256_k_rom (
    input  sha256_pkg::round_idx_t i_idx,
    output sha256_pkg::word_t      o_k
);

    always_comb
    begin
        case (i_idx)
            6'd0:    o_k = 32'h428a2f98;
            6'd1:    o_k = 32'h71374491;
            6'd2:    o_k = 32'hb5c0fbcf;
            6'd3:    o_k = 32'he9b5dba5;
            6'd4:    o_k = 32'h3956c25b;
            6'd5:    o_k = 32'h59f111f1;
            6'd6:    o_k = 32'h923f82a4;
            6'd7:    o_k = 32'hab1c5ed5;
            6'd8:    o_k = 32'hd807aa98;
            6'd9:    o_k = 32'h12835b01;
            6'd10:   o_k = 32'h243185be;
            6'd11:   o_k = 32'h550c7dc3;
            6'd12:   o_k = 32'h72be5d74;
            6'd13:   o_k = 32'h80deb1fe;
            6'd14:   o_k = 32'h9bdc06a7;
            6'd15:   o_k = 32'hc19bf174;
            6'd16:   o_k = 32'he49b69c1;
            6'd17:   o_k = 32'hefbe4786;
            6'd18:   o_k = 32'h0fc19dc6;
            6'd19:   o_k = 32'h240ca1cc;
            6'd20:   o_k = 32'h2de92c6f;
            6'd21:   o_k = 32'h4a7484aa;
            6'd22:   o_k = 32'h5cb0a9dc;
            6'd23:   o_k = 32'h76f988da;
            6'd24:   o_k = 32'h983e5152;
            6'd25:   o_k = 32'ha831c66d;
            6'd26:   o_k = 32'hb00327c8;
            6'd27:   o_k = 32'hbf597fc7;
            6'd28:   o_k = 32'hc6e00bf3;
            6'd29:   o_k = 32'hd5a79147;
            6'd30:   o_k = 32'h06ca6351;
            6'd31:   o_k = 32'h14292967;
            6'd32:   o_k = 32'h27b70a85;
            6'd33:   o_k = 32'h2e1b2138;
            6'd34:   o_k = 32'h4d2c6dfc;
            6'd35:   o_k = 32'h53380d13;
            6'd36:   o_k = 32'h650a7354;
            6'd37:   o_k = 32'h766a0abb;
            6'd38:   o_k = 32'h81c2c92e;
            6'd39:   o_k = 32'h92722c85;
            6'd40:   o_k = 32'ha2bfe8a1;
            6'd41:   o_k = 32'ha81a664b;
            6'd42:   o_k = 32'hc24b8b70;
            6'd43:   o_k = 32'hc76c51a3;
            6'd44:   o_k = 32'hd192e819;
            6'd45:   o_k = 32'hd6990624;
            6'd46:   o_k = 32'hf40e3585;
            6'd47:   o_k = 32'h106aa070;
            6'd48:   o_k = 32'h19a4c116;
            6'd49:   o_k = 32'h1e376c08;
            6'd50:   o_k = 32'h2748774c;
            6'd51:   o_k = 32'h34b0bcb5;
            6'd52:   o_k = 32'h391c0cb3;
            6'd53:   o_k = 32'h4ed8aa4a;
            6'd54:   o_k = 32'h5b9cca4f;
            6'd55:   o_k = 32'h682e6ff3;
            6'd56:   o_k = 32'h748f82ee;
            6'd57:   o_k = 32'h78a5636f;
            6'd58:   o_k = 32'h84c87814;
            6'd59:   o_k = 32'h8cc70208;
            6'd60:   o_k = 32'h90befffa;
            6'd61:   o_k = 32'ha4506ceb;
            6'd62:   o_k = 32'hbef9a3f7;
            default: o_k = 32'hc67178f2; // round 63
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/sha256_schedule.sv
`default_nettype none

`include "sha256_cfg.svh"

module sha256_schedule (
    input  logic                clk,
    input  logic                rst,
    input  logic                i_load,
    input  sha256_pkg::msg_t    i_msg,
    input  logic                i_round_en,
    output sha256_pkg::word_t   o_w
);

    localparam int ZERO_BITS = `SHA_BLOCK_BITS - `SHA_MSG_BITS - 1 - 64;

    logic [`SHA_BLOCK_BITS-1:0] pad_block;
    sha256_pkg::word_t [0:15]   win;       // win[0] is the oldest word
    sha256_pkg::word_t          next_w;

    ////////////////////////////////////////////////////////////////////////////
    // single block padding
    ////////////////////////////////////////////////////////////////////////////

    // message, one marker bit, zero fill, 64-bit bit length
    assign pad_block = {i_msg, 1'b1, {ZERO_BITS{1'b0}}, 64'(`SHA_MSG_BITS)};

    ////////////////////////////////////////////////////////////////////////////
    // sliding window
    ////////////////////////////////////////////////////////////////////////////

    // w[t+16] from w[t], w[t+1], w[t+9] and w[t+14]
    assign next_w = sha256_pkg::small_sigma1(win[14]) + win[9]
                  + sha256_pkg::small_sigma0(win[1]) + win[0];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            win <= '0;
        end
        else if (i_load)
        begin
            win <= pad_block;    // ascending range puts the first block word in win[0]
        end
        else if (i_round_en)
        begin
            win <= {win[1:15], next_w};
        end
    end

    assign o_w = win[0];

endmodule

`default_nettype wire

// File: hdl/sha256_compress.sv
`default_nettype none

`include "sha256_cfg.svh"

module sha256_compress (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_load,
    input  logic                    i_round_en,
    input  logic                    i_finish,
    input  sha256_pkg::word_t       i_w,
    input  sha256_pkg::word_t       i_k,
    output sha256_pkg::work_state_t o_digest
);

    localparam sha256_pkg::work_state_t H_INIT = '{
        a: `SHA_H0, b: `SHA_H1, c: `SHA_H2, d: `SHA_H3,
        e: `SHA_H4, f: `SHA_H5, g: `SHA_H6, h: `SHA_H7
    };

    sha256_pkg::work_state_t st;
    sha256_pkg::work_state_t digest_q;
    sha256_pkg::word_t       t1;
    sha256_pkg::word_t       t2;

    // round temporaries
    always_comb
    begin
        t1 = st.h + sha256_pkg::big_sigma1(st.e) + sha256_pkg::ch(st.e, st.f, st.g)
           + i_k + i_w;
        t2 = sha256_pkg::big_sigma0(st.a) + sha256_pkg::maj(st.a, st.b, st.c);
    end

    always_ff @(posedge clk)
    begin
        if (i_load)
        begin
            st <= H_INIT;
        end
        else if (i_round_en)
        begin
            st <= '{a: t1 + t2, b: st.a, c: st.b, d: st.c,
                    e: st.d + t1, f: st.e, g: st.f, h: st.g};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // final addition of the initial hash
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            digest_q <= '0;
        end
        else if (i_finish)
        begin
            digest_q.a <= st.a + H_INIT.a;
            digest_q.b <= st.b + H_INIT.b;
            digest_q.c <= st.c + H_INIT.c;
            digest_q.d <= st.d + H_INIT.d;
            digest_q.e <= st.e + H_INIT.e;
            digest_q.f <= st.f + H_INIT.f;
            digest_q.g <= st.g + H_INIT.g;
            digest_q.h <= st.h + H_INIT.h;
        end
    end

    assign o_digest = digest_q;

endmodule

`default_nettype wire

// File: hdl/sha256_ctrl.sv
`default_nettype none

`include "sha256_cfg.svh"

module sha256_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_msg_valid,
    input  sha256_pkg::msg_t       i_msg,
    input  logic                   i_digest_credit,
    output logic                   o_msg_credit,
    output logic                   o_load,
    output sha256_pkg::msg_t       o_block_msg,
    output logic                   o_round_en,
    output sha256_pkg::round_idx_t o_round_idx,
    output logic                   o_finish,
    output logic                   o_digest_valid
);

    localparam int CREDIT_BITS = $clog2(`SHA_OUT_CREDITS + 1);
    localparam logic [CREDIT_BITS-1:0] CREDIT_MAX = CREDIT_BITS'(`SHA_OUT_CREDITS);
    localparam sha256_pkg::round_idx_t LAST_ROUND = sha256_pkg::round_idx_t'(`SHA_ROUNDS - 1);

    sha256_pkg::ctrl_state_e state;
    sha256_pkg::round_idx_t  round_cnt;
    logic                    slot_full;
    sha256_pkg::msg_t        slot_msg;
    logic [CREDIT_BITS-1:0]  out_credits;

    ////////////////////////////////////////////////////////////////////////////
    // input slot
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
            slot_full <= 1'b0;
        else if (i_msg_valid)
            slot_full <= 1'b1;
        else if (state == sha256_pkg::LOAD)
            slot_full <= 1'b0;    // message handed to the core
    end

    always_ff @(posedge clk)
    begin
        if (i_msg_valid)
            slot_msg <= i_msg;
    end

    // sequencer
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state     <= sha256_pkg::IDLE;
            round_cnt <= '0;
        end
        else
        begin
            case (state)
                sha256_pkg::IDLE:   if (slot_full) state <= sha256_pkg::LOAD;
                sha256_pkg::LOAD:
                begin
                    state     <= sha256_pkg::ROUND;
                    round_cnt <= '0;
                end
                sha256_pkg::ROUND:
                begin
                    round_cnt <= round_cnt + 1'b1;
                    if (round_cnt == LAST_ROUND)
                        state <= sha256_pkg::FINISH;
                end
                sha256_pkg::FINISH: state <= sha256_pkg::SEND;
                sha256_pkg::SEND:   if (o_digest_valid) state <= sha256_pkg::IDLE;
                default:            state <= sha256_pkg::IDLE;
            endcase
        end
    end

    // output credits, saturating at the consumer depth
    always_ff @(posedge clk)
    begin
        if (rst)
            out_credits <= CREDIT_MAX;
        else if (i_digest_credit && !o_digest_valid && out_credits != CREDIT_MAX)
            out_credits <= out_credits + 1'b1;
        else if (o_digest_valid && !i_digest_credit)
            out_credits <= out_credits - 1'b1;
    end

    assign o_load         = (state == sha256_pkg::LOAD);
    assign o_msg_credit   = (state == sha256_pkg::LOAD);   // slot frees in this cycle
    assign o_block_msg    = slot_msg;
    assign o_round_en     = (state == sha256_pkg::ROUND);
    assign o_round_idx    = round_cnt;
    assign o_finish       = (state == sha256_pkg::FINISH);
    assign o_digest_valid = (state == sha256_pkg::SEND) && (out_credits != '0);

endmodule

`default_nettype wire

// File: hdl/sha256_top.sv
`default_nettype none

`include "sha256_cfg.svh"

module sha256_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_msg_valid,
    input  sha256_pkg::msg_t        i_msg,
    output logic                    o_msg_credit,
    output logic                    o_digest_valid,
    output sha256_pkg::work_state_t o_digest,
    input  logic                    i_digest_credit
);

    logic                   load;
    logic                   round_en;
    logic                   finish;
    sha256_pkg::msg_t       block_msg;
    sha256_pkg::round_idx_t round_idx;
    sha256_pkg::word_t      k;
    sha256_pkg::word_t      w;

    sha256_ctrl ctrl_i (
        .clk             (clk),
        .rst             (rst),
        .i_msg_valid     (i_msg_valid),
        .i_msg           (i_msg),
        .i_digest_credit (i_digest_credit),
        .o_msg_credit    (o_msg_credit),
        .o_load          (load),
        .o_block_msg     (block_msg),
        .o_round_en      (round_en),
        .o_round_idx     (round_idx),
        .o_finish        (finish),
        .o_digest_valid  (o_digest_valid)
    );

    sha256_k_rom k_rom_i (.i_idx(round_idx), .o_k(k));

    sha256_schedule schedule_i (
        .clk        (clk),
        .rst        (rst),
        .i_load     (load),
        .i_msg      (block_msg),
        .i_round_en (round_en),
        .o_w        (w)
    );

    sha256_compress compress_i (
        .clk        (clk),
        .rst        (rst),
        .i_load     (load),
        .i_round_en (round_en),
        .i_finish   (finish),
        .i_w        (w),
        .i_k        (k),
        .o_digest   (o_digest)
    );

endmodule

`default_nettype wire

// File: verification/sha256_ref.svh
`ifndef SHA256_REF_SVH
`define SHA256_REF_SVH

////////////////////////////////////////////////////////////////////////////
// software model of a single block SHA-256
////////////////////////////////////////////////////////////////////////////

function automatic logic [31:0] ror32(input logic [31:0] x, input int n);
    return (x >> n) | (x << (32 - n));
endfunction

// first 32 fractional bits of p**e, as the standard defines H and K
function automatic logic [31:0] root_frac(input int p, input real e);
    real pr;
    real r;
    int  hi;
    int  lo;
    pr = p;
    r  = pr ** e;
    r  = (r - $floor(r)) * 65536.0;
    hi = $rtoi(r);
    lo = $rtoi((r - hi) * 65536.0);    // split keeps each half inside an int
    return {hi[15:0], lo[15:0]};
endfunction

function automatic logic [255:0] sha256_ref(input logic [23:0] msg);
    logic [31:0]  k  [0:63];
    logic [31:0]  w  [0:63];
    logic [31:0]  hv [0:7];
    logic [31:0]  v  [0:7];
    logic [511:0] blk;
    logic [255:0] res;
    logic [31:0]  t1;
    logic [31:0]  t2;
    int           n;
    int           cand;
    bit           prime;
    // H from square roots and K from cube roots of the first primes
    n    = 0;
    cand = 2;
    while (n < 64)
    begin
        prime = 1'b1;
        for (int d = 2; d * d <= cand; d++)
            if (cand % d == 0)
                prime = 1'b0;
        if (prime)
        begin
            if (n < 8)
                hv[n] = root_frac(cand, 0.5);
            k[n] = root_frac(cand, 1.0 / 3.0);
            n++;
        end
        cand++;
    end
    blk = {msg, 1'b1, 423'd0, 64'd24};    // 24-bit message, marker, fill, length
    for (int t = 0; t < 64; t++)
    begin
        if (t < 16)
            w[t] = blk[511 - 32 * t -: 32];
        else
            w[t] = (ror32(w[t-2], 17) ^ ror32(w[t-2], 19) ^ (w[t-2] >> 10)) + w[t-7]
                 + (ror32(w[t-15], 7) ^ ror32(w[t-15], 18) ^ (w[t-15] >> 3)) + w[t-16];
    end
    for (int j = 0; j < 8; j++)
        v[j] = hv[j];
    for (int t = 0; t < 64; t++)
    begin
        t1 = v[7] + (ror32(v[4], 6) ^ ror32(v[4], 11) ^ ror32(v[4], 25))
           + ((v[4] & v[5]) ^ (~v[4] & v[6])) + k[t] + w[t];
        t2 = (ror32(v[0], 2) ^ ror32(v[0], 13) ^ ror32(v[0], 22))
           + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
        for (int j = 7; j > 0; j--)
            v[j] = v[j-1];
        v[4] = v[4] + t1;    // old d plus t1
        v[0] = t1 + t2;
    end
    for (int j = 0; j < 8; j++)
        res[255 - 32 * j -: 32] = hv[j] + v[j];
    return res;
endfunction

`endif

// File: verification/sha256_tb.sv
`default_nettype none

`include "sha256_cfg.svh"

module sha256_tb;

    `include "sha256_ref.svh"

    localparam int NUM_MSGS = 1 + 20 + 6;    // abc, random stream, back-pressure

    logic                    clk             = 1'b0;
    logic                    rst             = 1'b1;
    logic                    i_msg_valid     = 1'b0;
    sha256_pkg::msg_t        i_msg           = '0;
    logic                    i_digest_credit = 1'b0;
    logic                    o_msg_credit;
    logic                    o_digest_valid;
    sha256_pkg::work_state_t o_digest;

    logic         hold         = 1'b0;    // consumer withholds credits
    logic [255:0] expected[$];
    integer       seed         = 32'haa46_9403;
    int           checks       = 0;
    int           errors       = 0;
    int           sent         = 0;
    int           owed         = 0;
    int           returned     = 0;       // o_msg_credit pulses seen
    int           accepted     = 0;       // i_msg_valid pulses seen
    int           granted      = `SHA_OUT_CREDITS;
    int           digests_seen = 0;

    sha256_top dut_i (
        .clk             (clk),
        .rst             (rst),
        .i_msg_valid     (i_msg_valid),
        .i_msg           (i_msg),
        .o_msg_credit    (o_msg_credit),
        .o_digest_valid  (o_digest_valid),
        .o_digest        (o_digest),
        .i_digest_credit (i_digest_credit)
    );

    always #20 clk = ~clk;

    task automatic check_value(input string name, input logic [255:0] got,
                               input logic [255:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            $display("ERROR %s expected 0x%0h actual 0x%0h", name, exp, got);
            errors++;
        end
    endtask

    task automatic check_cond(input bit ok, input string what);
        checks++;
        assert (ok)
        else
        begin
            $display("error at %0t: %s", $time, what);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (errors == errs_before)
            $display("test %s: ok", name);
        else
            $display("test %s: failed with %0d errors", name, errors - errs_before);
    endtask

    // producer task is called just after a rising edge
    task automatic send_msg(input logic [23:0] m);
        while (`SHA_IN_CREDITS + returned - sent <= 0)
            @(posedge clk);
        i_msg_valid <= 1'b1;
        i_msg       <= m;
        sent++;
        expected.push_back(sha256_ref(m));
        @(posedge clk);
        i_msg_valid <= 1'b0;
    endtask

    task automatic drain();
        while (digests_seen != sent)
            @(posedge clk);
        repeat (4) @(posedge clk);    // let the last credit return settle
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // consumer, credit monitor and digest checker
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk)
    begin
        if (rst)
        begin
            owed = 0;
            i_digest_credit <= 1'b0;
        end
        else
        begin
            owed = owed + int'(o_digest_valid);
            if (!hold && owed > 0)
            begin
                i_digest_credit <= 1'b1;
                owed = owed - 1;
            end
            else
                i_digest_credit <= 1'b0;
        end
    end

    always @(posedge clk)
    begin
        int in_count;    // producer credits as seen at this edge
        if (rst)
        begin
            returned     <= 0;
            accepted     <= 0;
            granted      <= `SHA_OUT_CREDITS;
            digests_seen <= 0;
        end
        else
        begin
            returned     <= returned + int'(o_msg_credit);
            accepted     <= accepted + int'(i_msg_valid);
            granted      <= granted + int'(i_digest_credit);
            digests_seen <= digests_seen + int'(o_digest_valid);
            in_count = `SHA_IN_CREDITS + returned + int'(o_msg_credit)
                     - accepted - int'(i_msg_valid);
            check_cond(in_count >= 0 && in_count <= `SHA_IN_CREDITS,
                       "producer credit count left the range of the input slots");
            check_cond(digests_seen + int'(o_digest_valid) <= granted + int'(i_digest_credit),
                       "DUT sent more digests than credits granted");
            if (o_digest_valid)
            begin
                if (expected.size() == 0)
                    check_cond(1'b0, "digest arrived with no message outstanding");
                else
                    check_value("o_digest", o_digest, expected.pop_front());
            end
        end
    end

    // watchdog
    initial
    begin
        #(NUM_MSGS * 100 * 40);
        $display("timeout: run did not finish within %0d time units", NUM_MSGS * 100 * 40);
        $display("TEST FAIL");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        int errs_before;
        int ret_before;
        int base;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        errs_before = errors;
        repeat (20)
        begin
            @(posedge clk);
            check_value("o_digest_valid", o_digest_valid, 1'b0);
            check_value("o_msg_credit", o_msg_credit, 1'b0);
        end
        report_test("idle after reset", errs_before);

        errs_before = errors;
        base        = digests_seen;
        check_value("reference digest", sha256_ref(24'h616263),
                    256'hba7816bf8f01cfea414140de5dae2223b00361a396177a9cb410ff61f20015ad);
        send_msg(24'h616263);
        drain();
        check_cond(digests_seen - base == 1, "abc did not give exactly one digest");
        report_test("abc vector", errs_before);

        errs_before = errors;
        ret_before  = returned;
        for (int i = 0; i < 20; i++)
            send_msg(24'($random(seed)));
        drain();
        check_cond(returned - ret_before == 20, "message credit count differs from 20");
        report_test("random stream", errs_before);

        errs_before = errors;
        base        = digests_seen;
        hold <= 1'b1;
        fork
            begin
                for (int i = 0; i < 6; i++)
                    send_msg(24'($random(seed)));
            end
            begin
                while (digests_seen - base < `SHA_OUT_CREDITS)
                    @(posedge clk);
                repeat (150) @(posedge clk);    // DUT must stay silent here
                check_cond(digests_seen - base == `SHA_OUT_CREDITS,
                           "digests sent while consumer held its credits");
                hold <= 1'b0;
            end
        join
        drain();
        report_test("output back-pressure", errs_before);

        errs_before = errors;
        check_cond(returned == accepted, "message credits differ from accepted messages");
        report_test("input credit balance", errs_before);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: sha256_top.f
+incdir+hdl
+incdir+verification
hdl/sha256_pkg.sv
hdl/sha256_k_rom.sv
hdl/sha256_schedule.sv
hdl/sha256_compress.sv
hdl/sha256_ctrl.sv
hdl/sha256_top.sv
verification/sha256_tb.sv
